// ==== files.f ====
+incdir+include
verilog/lp20Pkg.sv
verilog/lpRegDecode.sv
verilog/lpCsra.sv
verilog/lpCounter.sv
verilog/lpControl.sv
verilog/lp20Top.sv
bench/lp20Tb.sv

// ==== bench/lp20Tb.sv ====
// Directed testbench for the LP20 register block
// Runs four-phase bus cycles and printer event pulses against lp20Top
// Keeps its own model of the CSRA bits and compares every readback

`default_nettype none
`timescale 1ns/1ps

`include "lp20_params.svh"

module lp20Tb import lp20Pkg::*;
;

   // About 60 bus cycles of under 10 clocks each, so this leaves a wide margin
   localparam int watchdogCycles = 20000;
   localparam int handshakeLimit = 64;
   localparam int xferCount      = 5;

   logic        clk;
   logic        rst;
   logic        req;
   busReqT      busReq;
   logic        ack;
   logic [15:0] rdata;
   prtStatusT   status;
   prtEventsT   events;
   logic        charXfer;
   logic        formFeed;
   logic        irq;

   int errors;
   int checks;

   // Expected CSRA state
   logic       expErr;
   logic       expPcz;
   logic       expUndc;
   logic       expDhld;
   logic       expDone;
   logic       expIe;
   logic       expPar;
   logic       expGo;
   logic [1:0] expXad;
   logic [1:0] expMode;

   lp20Top u_lp20Top (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .busReq   (busReq),
      .ack      (ack),
      .rdata    (rdata),
      .status   (status),
      .events   (events),
      .charXfer (charXfer),
      .formFeed (formFeed),
      .irq      (irq)
   );

   always #4 clk = ~clk;

   //////////////////////////////
   // Checking helpers
   //////////////////////////////

   task automatic checkValue(input string name, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("** Error [%s] expected %h, actual %h", name, exp, act);
      end
   endtask

   // CSRA word built from the model and the printer levels
   function automatic logic [15:0] expectedCsra();
      logic [15:0] v;
      v = '0;
      v[`LP_CSRA_ERR]                     = expErr;
      v[`LP_CSRA_PCZ]                     = expPcz;
      v[`LP_CSRA_UNDC]                    = expUndc;
      v[`LP_CSRA_VFURDY]                  = status.vfuRdy;
      v[`LP_CSRA_ONLINE]                  = status.online;
      v[`LP_CSRA_DHLD]                    = expDhld;
      v[`LP_CSRA_DONE]                    = expDone;
      v[`LP_CSRA_IE]                      = expIe;
      v[`LP_CSRA_XAD +: `LP_CSRA_XAD_W]   = expXad;
      v[`LP_CSRA_MODE +: `LP_CSRA_MODE_W] = expMode;
      v[`LP_CSRA_PAR]                     = expPar;
      v[`LP_CSRA_GO]                      = expGo;
      return v;
   endfunction

   //////////////////////////////
   // Bus tasks
   //////////////////////////////

   // Full four-phase cycle, returns with ack low again
   task automatic busCycle(input busReqT r, output logic [15:0] data);
      int n;
      @(posedge clk);
      #1;
      busReq = r;
      req    = 1'b1;
      n      = 0;
      while (!ack && n < handshakeLimit)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!ack)
      begin
         errors++;
         $display("Bus cycle to address %0d got no ack", r.addr);
      end
      data = rdata;
      req  = 1'b0;
      n    = 0;
      while (ack && n < handshakeLimit)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (ack)
      begin
         errors++;
         $display("Bus cycle to address %0d left ack stuck high", r.addr);
      end
   endtask

   task automatic busWrite(input logic [1:0] addr, input logic [15:0] data,
                           input logic lo, input logic hi);
      busReqT      r;
      logic [15:0] unused;
      r.addr   = addr;
      r.wdata  = data;
      r.write  = 1'b1;
      r.loByte = lo;
      r.hiByte = hi;
      busCycle(r, unused);
   endtask

   task automatic busRead(input logic [1:0] addr, output logic [15:0] data);
      busReqT r;
      r       = '0;
      r.addr  = addr;
      busCycle(r, data);
   endtask

   // Low-byte CSRA write, fields and GO
   task automatic csraLoWrite(input logic [15:0] data);
      expIe   = data[`LP_CSRA_IE];
      expPar  = data[`LP_CSRA_PAR];
      expXad  = data[`LP_CSRA_XAD +: `LP_CSRA_XAD_W];
      expMode = data[`LP_CSRA_MODE +: `LP_CSRA_MODE_W];
      if (data[`LP_CSRA_GO])
      begin
         // GO only accepted on-line with no error
         if (status.online && !expErr)
         begin
            expGo   = 1'b1;
            expUndc = 1'b0;
         end
         else
            expErr = 1'b1;
      end
      busWrite(`LP_ADDR_CSRA, data, 1'b1, 1'b0);
   endtask

   // High-byte CSRA write, INIT, ECLR and DHLD
   task automatic csraHiWrite(input logic [15:0] data);
      if (data[`LP_CSRA_INIT])
      begin
         expIe   = 1'b0;
         expPar  = 1'b0;
         expXad  = '0;
         expMode = '0;
         expDhld = 1'b0;
         expDone = 1'b1;
         expErr  = 1'b0;
         expPcz  = 1'b0;
         expGo   = 1'b0;
      end
      else
      begin
         if (data[`LP_CSRA_ECLR])
            expErr = 1'b0;
         expDhld = data[`LP_CSRA_DHLD];
      end
      busWrite(`LP_ADDR_CSRA, data, 1'b0, 1'b1);
   endtask

   task automatic counterWrite(input logic [1:0] addr, input logic [15:0] data);
      if (addr == `LP_ADDR_BCTR)
         expDone = 1'b0;
      if (addr == `LP_ADDR_PCTR)
         expPcz = 1'b0;
      busWrite(addr, data, 1'b1, 1'b1);
   endtask

   task automatic checkReg(input string name, input logic [1:0] addr, input logic [15:0] exp);
      logic [15:0] data;
      busRead(addr, data);
      checkValue(name, exp, data);
   endtask

   task automatic checkCsra(input string name);
      checkReg(name, `LP_ADDR_CSRA, expectedCsra());
   endtask

   // Read CSRA until one bit settles, then compare the whole word
   task automatic pollCsra(input string name, input int bitIdx, input logic val);
      logic [15:0] data;
      int          tries;
      tries = 0;
      busRead(`LP_ADDR_CSRA, data);
      while (data[bitIdx] !== val && tries < 16)
      begin
         busRead(`LP_ADDR_CSRA, data);
         tries++;
      end
      if (data[bitIdx] !== val)
      begin
         errors++;
         $display("%s: CSRA bit %0d never reached %b", name, bitIdx, val);
      end
      checkCsra(name);
   endtask

   task automatic waitIrq(input string name);
      int n;
      n = 0;
      while (!irq && n < 32)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!irq)
      begin
         errors++;
         $display("%s: irq did not rise", name);
      end
   endtask

   //////////////////////////////
   // Printer side pulses
   //////////////////////////////

   task automatic pulseXfer();
      @(posedge clk);
      #1 charXfer = 1'b1;
      @(posedge clk);
      #1 charXfer = 1'b0;
   endtask

   task automatic pulseFormFeed();
      @(posedge clk);
      #1 formFeed = 1'b1;
      @(posedge clk);
      #1 formFeed = 1'b0;
   endtask

   task automatic pulseEvent(input prtEventsT ev);
      @(posedge clk);
      #1 events = ev;
      @(posedge clk);
      #1 events = '0;
   endtask

   task automatic setStatus(input logic online, input logic vfuRdy, input logic lpe);
      @(posedge clk);
      #1;
      status.online = online;
      status.vfuRdy = vfuRdy;
      status.lpe    = lpe;
   endtask

   //////////////////////////////
   // Directed tests
   //////////////////////////////

   task automatic testFieldAccess();
      checkCsra("fields after reset");
      csraLoWrite((16'h1 << `LP_CSRA_IE) | (16'h2 << `LP_CSRA_MODE) |
                  (16'h1 << `LP_CSRA_PAR) | (16'h3 << `LP_CSRA_XAD));
      checkCsra("fields low write");
      // Low byte all set but strobed as high byte only
      csraHiWrite(16'h00FE);
      checkCsra("fields high-only write");
      csraHiWrite(16'h1 << `LP_CSRA_INIT);
      checkCsra("fields INIT");
      // VFU dropping is an error as well as a level change
      setStatus(1'b1, 1'b0, 1'b0);
      expErr = 1'b1;
      pollCsra("fields vfu low", `LP_CSRA_ERR, 1'b1);
      setStatus(1'b1, 1'b1, 1'b0);
      csraHiWrite(16'h1 << `LP_CSRA_ECLR);
      checkCsra("fields vfu back");
   endtask

   task automatic testByteCount();
      logic [15:0] count;
      count = 16'(-xferCount) & ((16'h1 << `LP_BCTR_W) - 16'h1);
      counterWrite(`LP_ADDR_BAR, 16'h1234);
      counterWrite(`LP_ADDR_BCTR, 16'(-xferCount));
      checkReg("bctr load", `LP_ADDR_BCTR, count);
      csraLoWrite(16'h1 << `LP_CSRA_IE);
      csraLoWrite((16'h1 << `LP_CSRA_IE) | (16'h1 << `LP_CSRA_GO));
      checkCsra("bctr go");
      for (int i = 0; i < xferCount; i++)
         pulseXfer();
      expDone = 1'b1;
      expGo   = 1'b0;
      waitIrq("bctr irq");
      checkReg("bctr bar", `LP_ADDR_BAR, 16'h1234 + 16'(xferCount));
      checkReg("bctr zero", `LP_ADDR_BCTR, 16'h0000);
      // Latched across reads of other registers
      checkValue("bctr irq held", 16'h0001, {15'b0, irq});
      // This read also acknowledges the interrupt
      checkCsra("bctr done");
      checkValue("bctr irq cleared", 16'h0000, {15'b0, irq});
      counterWrite(`LP_ADDR_BCTR, 16'h0000);
      checkCsra("bctr write clears done");
   endtask

   task automatic testPageCount();
      counterWrite(`LP_ADDR_PCTR, 16'hFFFE);
      csraLoWrite(16'h1 << `LP_CSRA_GO);
      checkCsra("pctr go");
      pulseFormFeed();
      pulseFormFeed();
      expPcz = 1'b1;
      expGo  = 1'b0;
      pollCsra("pctr zero", `LP_CSRA_PCZ, 1'b1);
      checkReg("pctr value", `LP_ADDR_PCTR, 16'h0000);
      counterWrite(`LP_ADDR_PCTR, 16'hFFFE);
      checkCsra("pctr write clears pcz");
      // No step while GO is low
      pulseXfer();
      checkReg("pctr bar idle", `LP_ADDR_BAR, 16'h1234 + 16'(xferCount));
   endtask

   task automatic testErrors();
      prtEventsT ev;
      ev     = '0;
      ev.mpe = 1'b1;
      csraLoWrite(16'h1 << `LP_CSRA_GO);
      checkCsra("err mpe go");
      pulseEvent(ev);
      expErr = 1'b1;
      expGo  = 1'b0;
      pollCsra("err mpe", `LP_CSRA_ERR, 1'b1);
      csraHiWrite(16'h1 << `LP_CSRA_ECLR);
      checkCsra("err mpe eclr");
      // Printer going off-line
      csraLoWrite(16'h1 << `LP_CSRA_GO);
      checkCsra("err online go");
      setStatus(1'b0, 1'b1, 1'b0);
      expErr = 1'b1;
      expGo  = 1'b0;
      pollCsra("err online", `LP_CSRA_ERR, 1'b1);
      setStatus(1'b1, 1'b1, 1'b0);
      csraHiWrite(16'h1 << `LP_CSRA_ECLR);
      checkCsra("err online eclr");
      // Parity line rising
      csraLoWrite(16'h1 << `LP_CSRA_GO);
      checkCsra("err lpe go");
      setStatus(1'b1, 1'b1, 1'b1);
      expErr = 1'b1;
      expGo  = 1'b0;
      pollCsra("err lpe", `LP_CSRA_ERR, 1'b1);
      setStatus(1'b1, 1'b1, 1'b0);
      csraHiWrite(16'h1 << `LP_CSRA_ECLR);
      checkCsra("err lpe eclr");
      // GO while off-line, after clearing the off-line edge error
      setStatus(1'b0, 1'b1, 1'b0);
      expErr = 1'b1;
      pollCsra("err offline edge", `LP_CSRA_ERR, 1'b1);
      csraHiWrite(16'h1 << `LP_CSRA_ECLR);
      checkCsra("err offline eclr");
      csraLoWrite(16'h1 << `LP_CSRA_GO);
      pollCsra("err go offline", `LP_CSRA_ERR, 1'b1);
      setStatus(1'b1, 1'b1, 1'b0);
      csraHiWrite(16'h1 << `LP_CSRA_ECLR);
      checkCsra("err go offline eclr");
   endtask

   task automatic testUndcDhld();
      prtEventsT ev;
      ev      = '0;
      ev.undc = 1'b1;
      pulseEvent(ev);
      expUndc = 1'b1;
      pollCsra("undc set", `LP_CSRA_UNDC, 1'b1);
      csraLoWrite(16'h1 << `LP_CSRA_GO);
      checkCsra("undc cleared by go");
      ev         = '0;
      ev.setDhld = 1'b1;
      pulseEvent(ev);
      expDhld = 1'b1;
      pollCsra("dhld set", `LP_CSRA_DHLD, 1'b1);
      ev         = '0;
      ev.clrDhld = 1'b1;
      pulseEvent(ev);
      expDhld = 1'b0;
      pollCsra("dhld clear", `LP_CSRA_DHLD, 1'b0);
      csraHiWrite(16'h1 << `LP_CSRA_DHLD);
      checkCsra("dhld write one");
      csraHiWrite(16'h0000);
      checkCsra("dhld write zero");
   endtask

   //////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////

   initial
   begin
      clk       = 1'b0;
      rst       = 1'b1;
      req       = 1'b0;
      busReq    = '0;
      events    = '0;
      charXfer  = 1'b0;
      formFeed  = 1'b0;
      status    = '0;
      status.online = 1'b1;
      status.vfuRdy = 1'b1;
      errors    = 0;
      checks    = 0;
      expErr    = 1'b0;
      expPcz    = 1'b0;
      expUndc   = 1'b0;
      expDhld   = 1'b0;
      expDone   = 1'b0;
      expIe     = 1'b0;
      expPar    = 1'b0;
      expGo     = 1'b0;
      expXad    = '0;
      expMode   = '0;
      repeat (16) @(posedge clk);
      #1 rst = 1'b0;
      testFieldAccess();
      testByteCount();
      testPageCount();
      testErrors();
      testUndcDhld();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   initial
   begin
      repeat (watchdogCycles) @(posedge clk);
      $display("Watchdog expired after %0d cycles, tests did not finish", watchdogCycles);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/lp20Top.sv ====
// Top level of the LP20 register block
// Wires the bus decode, CSRA, transfer control and the three counters

`default_nettype none
`timescale 1ns/1ps

module lp20Top import lp20Pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        req,
   input  busReqT      busReq,
   output logic        ack,
   output logic [15:0] rdata,
   input  prtStatusT   status,
   input  prtEventsT   events,
   input  logic        charXfer,
   input  logic        formFeed,
   output logic        irq
);

   regWrT       regWr;
   logic        csraRead;
   logic [15:0] csraVal;
   csraCtlT     ctl;
   ctlEventsT   ctlEv;
   logic        setIrq;

   // Counter values and steps
   barT         barVal;
   bctrT        bctrVal;
   pctrT        pctrVal;
   logic        stepBar;
   logic        stepBctr;
   logic        stepPctr;
   logic        bctrZero;
   logic        pctrZero;

   //////////////////////////////
   // Bus side
   //////////////////////////////

   lpRegDecode u_decode (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .busReq   (busReq),
      .ack      (ack),
      .rdata    (rdata),
      .regWr    (regWr),
      .csraRead (csraRead),
      .csraVal  (csraVal),
      .barVal   (barVal),
      .bctrVal  (bctrVal),
      .pctrVal  (pctrVal)
   );

   lpCsra u_csra (
      .clk     (clk),
      .rst     (rst),
      .regWr   (regWr),
      .status  (status),
      .events  (events),
      .ctlEv   (ctlEv),
      .ctl     (ctl),
      .setIrq  (setIrq),
      .csraVal (csraVal)
   );

   lpControl u_control (
      .clk      (clk),
      .rst      (rst),
      .ctl      (ctl),
      .status   (status),
      .charXfer (charXfer),
      .formFeed (formFeed),
      .bctrZero (bctrZero),
      .pctrZero (pctrZero),
      .csraRead (csraRead),
      .setIrq   (setIrq),
      .ctlEv    (ctlEv),
      .stepBar  (stepBar),
      .stepBctr (stepBctr),
      .stepPctr (stepPctr),
      .irq      (irq)
   );

   //////////////////////////////
   // Counters
   //////////////////////////////

   // Address wrap has no meaning to control
   lpCounter #(.cntT(barT)) u_bar (
      .clk (clk), .rst (rst), .load (regWr.bar), .loadVal (regWr.wdata),
      .step (stepBar), .value (barVal), .zeroHit ()
   );

   lpCounter #(.cntT(bctrT)) u_bctr (
      .clk (clk), .rst (rst), .load (regWr.bctr), .loadVal (regWr.wdata),
      .step (stepBctr), .value (bctrVal), .zeroHit (bctrZero)
   );

   lpCounter #(.cntT(pctrT)) u_pctr (
      .clk (clk), .rst (rst), .load (regWr.pctr), .loadVal (regWr.wdata),
      .step (stepPctr), .value (pctrVal), .zeroHit (pctrZero)
   );

endmodule

`default_nettype wire

// ==== verilog/lpControl.sv ====
// LP20 transfer control
// Starts and ends GO, gates counter steps and latches the interrupt line

`default_nettype none
`timescale 1ns/1ps

module lpControl import lp20Pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  csraCtlT   ctl,
   input  prtStatusT status,
   input  logic      charXfer,
   input  logic      formFeed,
   input  logic      bctrZero,
   input  logic      pctrZero,
   input  logic      csraRead,
   input  logic      setIrq,
   output ctlEventsT ctlEv,
   output logic      stepBar,
   output logic      stepBctr,
   output logic      stepPctr,
   output logic      irq
);

   logic go;
   logic goCmd;
   logic goOk;

   //////////////////////////////
   // GO command
   //////////////////////////////

   assign goCmd = ctl.goWrite & ctl.goBit;
   // Printer must be on-line with no error pending
   assign goOk  = status.online & ~ctl.err;

   assign ctlEv.go      = go;
   assign ctlEv.cmdGo   = goCmd & goOk;
   assign ctlEv.setGoe  = goCmd & ~goOk;
   assign ctlEv.setDone = bctrZero;
   assign ctlEv.setPcz  = pctrZero;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         go <= 1'b0;
      // Byte count, page count, error or INIT end the transfer
      else if (ctl.init | ctl.err | bctrZero | pctrZero)
         go <= 1'b0;
      else if (ctlEv.cmdGo)
         go <= 1'b1;
   end

   // Data-path pulses only count while GO
   assign stepBar  = go & charXfer;
   assign stepBctr = go & charXfer;
   assign stepPctr = go & formFeed;

   //////////////////////////////
   // Interrupt latch
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         irq <= 1'b0;
      // Reading CSRA acknowledges
      else if (ctl.init | csraRead)
         irq <= 1'b0;
      else if (setIrq & ctl.ie)
         irq <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== verilog/lpCounter.sv ====
// Loadable up-counter used for the LP20 address, byte and page counters
// Payload type set by parameter, pulses zeroHit when a step wraps to zero

`default_nettype none
`timescale 1ns/1ps

module lpCounter #(
   parameter type cntT = logic [15:0]
)
(
   input  logic        clk,
   input  logic        rst,
   input  logic        load,
   input  logic [15:0] loadVal,
   input  logic        step,
   output cntT         value,
   output logic        zeroHit
);

   cntT nextVal;

   // Wraps at the payload width
   assign nextVal = value + cntT'(1);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         value   <= '0;
         zeroHit <= 1'b0;
      end
      else
      begin
         zeroHit <= 1'b0;
         // Host load wins over a step in the same cycle
         if (load)
            value <= loadVal[$bits(cntT)-1:0];
         else if (step)
         begin
            value   <= nextVal;
            zeroHit <= (nextVal == '0);
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/lpCsra.sv ====
// LP20 control and status register A
// Holds sticky status, host fields and the INIT and ECLR commands
// Also raises the interrupt-set pulse that control latches

`default_nettype none
`timescale 1ns/1ps

`include "lp20_params.svh"

module lpCsra import lp20Pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  regWrT       regWr,
   input  prtStatusT   status,
   input  prtEventsT   events,
   input  ctlEventsT   ctlEv,
   output csraCtlT     ctl,
   output logic        setIrq,
   output logic [15:0] csraVal
);

   logic hiWrite;
   logic loWrite;
   logic init;
   logic eclr;
   logic setErr;

   // Previous printer levels
   logic lastOnline;
   logic lastVfuRdy;
   logic lastLpe;

   // Register bits
   logic err;
   logic pcz;
   logic undc;
   logic dhld;
   logic done;
   logic ie;
   logic par;
   logic [`LP_CSRA_XAD_W-1:0]  xad;
   logic [`LP_CSRA_MODE_W-1:0] mode;

   assign hiWrite = regWr.csra & regWr.hiByte;
   assign loWrite = regWr.csra & regWr.loByte;

   // Write-only commands, only seen during the write cycle
   assign init = hiWrite & regWr.wdata[`LP_CSRA_INIT];
   assign eclr = init | (hiWrite & regWr.wdata[`LP_CSRA_ECLR]);

   //////////////////////////////
   // Printer edge watchers
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         lastOnline <= 1'b0;
         lastVfuRdy <= 1'b0;
         lastLpe    <= 1'b0;
      end
      else
      begin
         lastOnline <= status.online;
         lastVfuRdy <= status.vfuRdy;
         lastLpe    <= status.lpe;
      end
   end

   // Any error source, printer going off-line or VFU dropping counts too
   assign setErr = events.mpe | events.rpe | events.msyn | events.dte | ctlEv.setGoe |
                   (lastOnline & ~status.online) |
                   (lastVfuRdy & ~status.vfuRdy) |
                   (status.lpe & ~lastLpe);

   //////////////////////////////
   // Sticky status
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         err  <= 1'b0;
         pcz  <= 1'b0;
         undc <= 1'b0;
         dhld <= 1'b0;
         done <= 1'b0;
      end
      else
      begin
         // ERR
         if (eclr)
            err <= 1'b0;
         else if (setErr)
            err <= 1'b1;
         // PCZ, also cleared by loading the page counter
         if (init | regWr.pctr)
            pcz <= 1'b0;
         else if (ctlEv.setPcz)
            pcz <= 1'b1;
         // UNDC cleared by an accepted GO
         if (ctlEv.cmdGo)
            undc <= 1'b0;
         else if (events.undc)
            undc <= 1'b1;
         // DHLD, pulses first then a host write
         if (init | events.clrDhld)
            dhld <= 1'b0;
         else if (events.setDhld)
            dhld <= 1'b1;
         else if (hiWrite)
            dhld <= regWr.wdata[`LP_CSRA_DHLD];
         // DONE set by INIT too
         if (regWr.bctr)
            done <= 1'b0;
         else if (init | ctlEv.setDone)
            done <= 1'b1;
      end
   end

   //////////////////////////////
   // Host fields
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ie   <= 1'b0;
         par  <= 1'b0;
         xad  <= '0;
         mode <= '0;
      end
      else if (init)
      begin
         ie   <= 1'b0;
         par  <= 1'b0;
         xad  <= '0;
         mode <= '0;
      end
      else if (loWrite)
      begin
         ie   <= regWr.wdata[`LP_CSRA_IE];
         par  <= regWr.wdata[`LP_CSRA_PAR];
         xad  <= regWr.wdata[`LP_CSRA_XAD +: `LP_CSRA_XAD_W];
         mode <= regWr.wdata[`LP_CSRA_MODE +: `LP_CSRA_MODE_W];
      end
   end

   // Readback word
   always_comb
   begin
      csraVal                                     = '0;
      csraVal[`LP_CSRA_ERR]                       = err;
      csraVal[`LP_CSRA_PCZ]                       = pcz;
      csraVal[`LP_CSRA_UNDC]                      = undc;
      csraVal[`LP_CSRA_VFURDY]                    = status.vfuRdy;
      csraVal[`LP_CSRA_ONLINE]                    = status.online;
      csraVal[`LP_CSRA_DHLD]                      = dhld;
      csraVal[`LP_CSRA_ECLR]                      = eclr;
      csraVal[`LP_CSRA_INIT]                      = init;
      csraVal[`LP_CSRA_DONE]                      = done;
      csraVal[`LP_CSRA_IE]                        = ie;
      csraVal[`LP_CSRA_XAD +: `LP_CSRA_XAD_W]     = xad;
      csraVal[`LP_CSRA_MODE +: `LP_CSRA_MODE_W]   = mode;
      csraVal[`LP_CSRA_PAR]                       = par;
      csraVal[`LP_CSRA_GO]                        = ctlEv.go;
   end

   // To control
   assign ctl.init    = init;
   assign ctl.err     = err;
   assign ctl.ie      = ie;
   assign ctl.goWrite = loWrite;
   assign ctl.goBit   = regWr.wdata[`LP_CSRA_GO];

   // Interrupt causes, including any change of VFU-ready or on-line
   assign setIrq = setErr | ctlEv.setPcz | events.undc | ctlEv.setDone |
                   (status.vfuRdy ^ lastVfuRdy) | (status.online ^ lastOnline);

endmodule

`default_nettype wire

// ==== verilog/lpRegDecode.sv ====
// Four-phase req/ack bus slave for the LP20 registers
// Each request gives one write strobe or read pulse and returns read data on ack

`default_nettype none
`timescale 1ns/1ps

`include "lp20_params.svh"

module lpRegDecode import lp20Pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        req,
   input  busReqT      busReq,
   output logic        ack,
   output logic [15:0] rdata,
   output regWrT       regWr,
   output logic        csraRead,
   input  logic [15:0] csraVal,
   input  barT         barVal,
   input  bctrT        bctrVal,
   input  pctrT        pctrVal
);

   // Sampled req and its previous value
   logic   reqQ;
   logic   reqPrev;
   logic   accept;
   regWrT  wrNext;
   logic [15:0] readMux;

   // New request only on a rising req with ack low
   assign accept = reqQ & ~reqPrev & ~ack;

   //////////////////////////////
   // Write strobe decode
   //////////////////////////////

   always_comb
   begin
      wrNext        = '0;
      wrNext.wdata  = busReq.wdata;
      wrNext.loByte = busReq.loByte;
      wrNext.hiByte = busReq.hiByte;
      case (busReq.addr)
         `LP_ADDR_CSRA: wrNext.csra = 1'b1;
         `LP_ADDR_BAR:  wrNext.bar  = 1'b1;
         `LP_ADDR_BCTR: wrNext.bctr = 1'b1;
         default:       wrNext.pctr = 1'b1;
      endcase
   end

   // Read mux, narrow counters zero-extended
   always_comb
   begin
      case (busReq.addr)
         `LP_ADDR_CSRA: readMux = csraVal;
         `LP_ADDR_BAR:  readMux = barVal;
         `LP_ADDR_BCTR: readMux = {{(16-`LP_BCTR_W){1'b0}}, bctrVal};
         default:       readMux = {{(16-`LP_PCTR_W){1'b0}}, pctrVal};
      endcase
   end

   //////////////////////////////
   // Handshake FSM
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         reqQ     <= 1'b0;
         reqPrev  <= 1'b0;
         ack      <= 1'b0;
         regWr    <= '0;
         csraRead <= 1'b0;
      end
      else
      begin
         reqQ     <= req;
         reqPrev  <= reqQ;
         // Strobes last one cycle
         regWr    <= '0;
         csraRead <= 1'b0;
         if (accept)
         begin
            ack <= 1'b1;
            if (busReq.write)
               regWr <= wrNext;
            else
               csraRead <= (busReq.addr == `LP_ADDR_CSRA);
         end
         // Host has let go of req
         else if (ack && !reqQ)
            ack <= 1'b0;
      end
   end

   // Read data held while ack is high
   always_ff @(posedge clk)
   begin
      if (accept)
         rdata <= readMux;
   end

endmodule

`default_nettype wire

// ==== verilog/lp20Pkg.sv ====
// Shared types for the LP20 register block
// Bus request, internal strobes, printer status and events, counter payloads

`default_nettype none

`include "lp20_params.svh"

package lp20Pkg;

   // Host request, held stable while req is high
   typedef struct packed {
      logic [1:0]  addr;
      logic [15:0] wdata;
      logic        write;
      logic        loByte;
      logic        hiByte;
   } busReqT;

   // One-cycle register write strobes plus the written word
   typedef struct packed {
      logic        csra;
      logic        bar;
      logic        bctr;
      logic        pctr;
      logic        loByte;
      logic        hiByte;
      logic [15:0] wdata;
   } regWrT;

   // Printer levels
   typedef struct packed {
      logic online;
      logic vfuRdy;
      logic lpe;
   } prtStatusT;

   // Pulses from the data path
   typedef struct packed {
      logic mpe;
      logic rpe;
      logic msyn;
      logic dte;
      logic undc;
      logic setDhld;
      logic clrDhld;
   } prtEventsT;

   // CSRA towards control
   typedef struct packed {
      logic init;
      logic err;
      logic ie;
      logic goWrite;
      logic goBit;
   } csraCtlT;

   // Control towards CSRA, all pulses except go
   typedef struct packed {
      logic go;
      logic cmdGo;
      logic setGoe;
      logic setDone;
      logic setPcz;
   } ctlEventsT;

   // Counter payloads
   typedef logic [`LP_BAR_W-1:0]  barT;
   typedef logic [`LP_BCTR_W-1:0] bctrT;
   typedef logic [`LP_PCTR_W-1:0] pctrT;

endpackage

`default_nettype wire

// ==== include/lp20_params.svh ====
// Register map, CSRA bit positions and counter widths for the LP20 register block
// Included by the package and by any module that decodes addresses or CSRA bits

`ifndef LP20_PARAMS_SVH
`define LP20_PARAMS_SVH

//////////////////////////////
// Word addresses on the bus
//////////////////////////////

`define LP_ADDR_CSRA      2'd0
`define LP_ADDR_BAR       2'd1
`define LP_ADDR_BCTR      2'd2
`define LP_ADDR_PCTR      2'd3

//////////////////////////////
// CSRA bit positions
//////////////////////////////

`define LP_CSRA_ERR       15
`define LP_CSRA_PCZ       14
`define LP_CSRA_UNDC      13
`define LP_CSRA_VFURDY    12
`define LP_CSRA_ONLINE    11
`define LP_CSRA_DHLD      10
`define LP_CSRA_ECLR      9
`define LP_CSRA_INIT      8
`define LP_CSRA_DONE      7
`define LP_CSRA_IE        6
// Two-bit fields as low bit plus width
`define LP_CSRA_XAD       4
`define LP_CSRA_XAD_W     2
`define LP_CSRA_MODE      2
`define LP_CSRA_MODE_W    2
`define LP_CSRA_PAR       1
`define LP_CSRA_GO        0

//////////////////////////////
// Counter widths
//////////////////////////////

`define LP_BAR_W          16
`define LP_BCTR_W         12
`define LP_PCTR_W         12

`endif
